// File: run.sh
#!/usr/bin/env bash
# build the execute stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module executeStageTb \
    -o executeStageSim || { echo "Verilator build error"; exit 1; }
./obj_dir/executeStageSim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation PASSED"

// File: source/divUnit.sv
// Radix-2 restoring divider
// one load cycle, 32 shift-subtract steps, one sign fix cycle
// divide by zero and signed overflow follow the RISC-V rules
`timescale 1ns/1ps
`default_nettype none

module divUnit (
    input logic clk,
    input logic arstN,
    input logic enable,
    input logic stall,
    input logic flush,
    input logic isSigned,
    input rvPkg::word dividend,
    input rvPkg::word divisor,
    output logic done,
    output rvPkg::word quotient,
    output rvPkg::word remainder
);
    logic running;
    logic [5:0] count;

    logic dividendNeg;
    logic divisorNeg;
    rvPkg::word absDividend;
    rvPkg::word absDivisor;

    rvPkg::word quo;
    rvPkg::word rem;
    rvPkg::word div;
    logic negQuo;
    logic negRem;
    logic [32:0] shifted;

    always_comb begin
        dividendNeg = isSigned & dividend[31];
        divisorNeg = isSigned & divisor[31];
        absDividend = dividendNeg ? -dividend : dividend;
        absDivisor = divisorNeg ? -divisor : divisor;
        shifted = {rem, quo[31]};
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            running <= 1'b0;
            done <= 1'b0;
            count <= '0;
        end else if (flush || !enable) begin
            running <= 1'b0;
            done <= 1'b0;
            count <= '0;
        end else if (!stall) begin
            if (done) begin
                done <= 1'b0;
            end else if (!running) begin
                running <= 1'b1;
                count <= '0;
            end else if (count == 6'(rvPkg::xLen)) begin
                running <= 1'b0;
                done <= 1'b1;
            end else begin
                count <= count + 6'd1;
            end
        end
    end

    // 0x80000000 / -1 needs no special case, the unsigned core already
    // gives quotient 0x80000000 and remainder 0 with no negation
    always_ff @(posedge clk) begin
        if (!stall && !done) begin
            if (!running) begin
                quo <= absDividend;
                rem <= '0;
                div <= absDivisor;
                // divide by zero keeps quotient all ones
                negQuo <= (dividendNeg ^ divisorNeg) && (divisor != '0);
                negRem <= dividendNeg;
            end else if (count != 6'(rvPkg::xLen)) begin
                if (shifted >= {1'b0, div}) begin
                    rem <= rvPkg::word'(shifted - {1'b0, div});
                    quo <= {quo[30:0], 1'b1};
                end else begin
                    rem <= shifted[31:0];
                    quo <= {quo[30:0], 1'b0};
                end
            end else begin
                quotient <= negQuo ? -quo : quo;
                remainder <= negRem ? -rem : rem;
            end
        end
    end

    stepCountBound: assert property (
        @(posedge clk) disable iff (!arstN) count <= 6'(rvPkg::xLen)
    );

endmodule

`default_nettype wire

// File: source/execPkg.sv
// Execute stage pipeline types
// decoded operation, stage input and output records, trap record
`default_nettype none

package execPkg;

    localparam int regAddrWidth = 5;

    typedef logic [regAddrWidth-1:0] regAddr;

    typedef enum logic [1:0] {
        src1Zero,
        src1Pc,
        src1Reg
    } aluSrcType1;

    typedef enum logic [1:0] {
        src2Zero,
        src2Imm,
        src2Reg
    } aluSrcType2;

    typedef enum logic {
        intResultAlu,
        intResultMulDiv
    } intResultType;

    typedef enum logic {
        writeSrcResult,
        writeSrcNextPc
    } writeSrcType;

    typedef enum logic [1:0] {
        trapOpNone,
        trapOpEcall,
        trapOpEbreak
    } trapOpType;

    typedef struct packed {
        rvPkg::aluCommand aluCmd;
        aluSrcType1 srcType1;
        aluSrcType2 srcType2;
        rvPkg::word imm;
        intResultType resultType;
        rvPkg::mulDivType mulDivKind;
        logic isBranch;
        rvPkg::branchType branchKind;
        writeSrcType writeSrc;
        logic regWriteEnable;
        logic isLoad;
        logic isStore;
        trapOpType trapOp;
    } decodedOp;

    typedef struct packed {
        logic valid;
        rvPkg::exceptionCode cause;
    } trapInfo;

    // from register read
    typedef struct packed {
        logic valid;
        decodedOp op;
        rvPkg::word pc;
        rvPkg::word srcValue1;
        rvPkg::word srcValue2;
        regAddr dstRegAddr;
    } regReadOut;

    // to memory stage
    typedef struct packed {
        logic valid;
        decodedOp op;
        rvPkg::word pc;
        regAddr dstRegAddr;
        rvPkg::word dstValue;
        rvPkg::word memAddr;
        rvPkg::word storeValue;
        logic branchTaken;
        rvPkg::word branchTarget;
        trapInfo trap;
    } executeOut;

endpackage

`default_nettype wire

// File: source/executeStage.sv
// RV32IM execute stage
// operand select, ALU, branch compare, ecall/ebreak traps
// multi-cycle multiply/divide with stall request, one output register
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input logic clk,
    input logic arstN,
    input execPkg::regReadOut prevStage,
    input logic stall,
    input logic flush,
    output logic stallReq,
    output execPkg::executeOut nextStage
);
    logic valid;
    execPkg::decodedOp op;
    logic mulDivEnable;
    logic mulDivDone;
    rvPkg::word mulDivResult;
    rvPkg::word aluSrc1;
    rvPkg::word aluSrc2;
    rvPkg::word aluResult;
    rvPkg::word intResult;
    rvPkg::word dstValue;
    logic branchTaken;
    execPkg::trapInfo trap;
    execPkg::executeOut stageResult;

    function automatic rvPkg::word alu(rvPkg::aluCommand cmd, rvPkg::word a, rvPkg::word b);
        logic [rvPkg::xLenLog2-1:0] shamt;
        shamt = b[rvPkg::xLenLog2-1:0];
        case (cmd)
            rvPkg::aluAdd: return a + b;
            rvPkg::aluSub: return a - b;
            rvPkg::aluSll: return a << shamt;
            rvPkg::aluSlt: return rvPkg::word'($signed(a) < $signed(b));
            rvPkg::aluSltu: return rvPkg::word'(a < b);
            rvPkg::aluXor: return a ^ b;
            rvPkg::aluSrl: return a >> shamt;
            rvPkg::aluSra: return $signed(a) >>> shamt;
            rvPkg::aluOr: return a | b;
            rvPkg::aluAnd: return a & b;
            default: return '0;
        endcase
    endfunction

    function automatic logic branchCompare(rvPkg::branchType kind, rvPkg::word a, rvPkg::word b);
        case (kind)
            rvPkg::branchEqual: return a == b;
            rvPkg::branchNotEqual: return a != b;
            rvPkg::branchLessThan: return $signed(a) < $signed(b);
            rvPkg::branchGreaterEqual: return $signed(a) >= $signed(b);
            rvPkg::branchUnsignedLessThan: return a < b;
            rvPkg::branchUnsignedGreaterEqual: return a >= b;
            rvPkg::branchAlways: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    always_comb begin
        valid = prevStage.valid && !flush;
        op = prevStage.op;
        mulDivEnable = valid && (op.resultType == execPkg::intResultMulDiv);
        stallReq = mulDivEnable && !mulDivDone;
    end

    mulDivUnit mulDiv (
        .clk(clk),
        .arstN(arstN),
        .enable(mulDivEnable),
        .stall(stall),
        .flush(flush),
        .kind(op.mulDivKind),
        .src1(prevStage.srcValue1),
        .src2(prevStage.srcValue2),
        .done(mulDivDone),
        .result(mulDivResult)
    );

    // operand select
    always_comb begin
        case (op.srcType1)
            execPkg::src1Pc: aluSrc1 = prevStage.pc;
            execPkg::src1Reg: aluSrc1 = prevStage.srcValue1;
            default: aluSrc1 = '0;
        endcase
        case (op.srcType2)
            execPkg::src2Imm: aluSrc2 = op.imm;
            execPkg::src2Reg: aluSrc2 = prevStage.srcValue2;
            default: aluSrc2 = '0;
        endcase
    end

    always_comb begin
        aluResult = alu(op.aluCmd, aluSrc1, aluSrc2);
        intResult = (op.resultType == execPkg::intResultMulDiv) ? mulDivResult : aluResult;
        // link value for jal/jalr
        if (op.writeSrc == execPkg::writeSrcNextPc) begin
            dstValue = prevStage.pc + rvPkg::insnSize;
        end else begin
            dstValue = intResult;
        end
        branchTaken = op.isBranch &&
                      branchCompare(op.branchKind, prevStage.srcValue1, prevStage.srcValue2);
    end

    // machine mode only
    always_comb begin
        trap = '0;
        if (valid && op.trapOp == execPkg::trapOpEcall) begin
            trap.valid = 1'b1;
            trap.cause = rvPkg::excEcallFromMachine;
        end else if (valid && op.trapOp == execPkg::trapOpEbreak) begin
            trap.valid = 1'b1;
            trap.cause = rvPkg::excBreakpoint;
        end
    end

    always_comb begin
        stageResult.valid = valid;
        stageResult.op = op;
        stageResult.pc = prevStage.pc;
        stageResult.dstRegAddr = prevStage.dstRegAddr;
        stageResult.dstValue = dstValue;
        stageResult.memAddr = aluResult;
        stageResult.storeValue = prevStage.srcValue2;
        stageResult.branchTaken = branchTaken;
        stageResult.branchTarget = aluResult;
        stageResult.trap = trap;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            nextStage <= '0;
        end else if (flush) begin
            nextStage <= '0;
        end else if (stall) begin
            nextStage <= nextStage;
        end else if (stallReq) begin
            // bubble while multiply/divide runs
            nextStage <= '0;
        end else begin
            nextStage <= stageResult;
        end
    end

    // the multiply/divide op must stay presented while it runs
    stallReqHoldsInput: assert property (
        @(posedge clk) disable iff (!arstN || flush)
        stallReq |=> $stable(prevStage)
    );

endmodule

`default_nettype wire

// File: source/mulDivUnit.sv
// Multiply/divide wrapper
// decodes the M-extension kind, enables one unit and returns its result
`timescale 1ns/1ps
`default_nettype none

module mulDivUnit (
    input logic clk,
    input logic arstN,
    input logic enable,
    input logic stall,
    input logic flush,
    input rvPkg::mulDivType kind,
    input rvPkg::word src1,
    input rvPkg::word src2,
    output logic done,
    output rvPkg::word result
);
    logic isMul;
    logic mulHigh;
    logic mulSigned1;
    logic mulSigned2;
    logic divSigned;
    logic mulDone;
    logic divDone;
    rvPkg::word mulResult;
    rvPkg::word quotient;
    rvPkg::word remainder;

    always_comb begin
        isMul = kind inside {rvPkg::mulDivMul, rvPkg::mulDivMulh,
                             rvPkg::mulDivMulhsu, rvPkg::mulDivMulhu};
        mulHigh = kind inside {rvPkg::mulDivMulh, rvPkg::mulDivMulhsu, rvPkg::mulDivMulhu};
        mulSigned1 = kind inside {rvPkg::mulDivMulh, rvPkg::mulDivMulhsu};
        mulSigned2 = (kind == rvPkg::mulDivMulh);
        divSigned = kind inside {rvPkg::mulDivDiv, rvPkg::mulDivRem};
    end

    mulUnit mul (
        .clk(clk),
        .arstN(arstN),
        .enable(enable && isMul),
        .stall(stall),
        .flush(flush),
        .high(mulHigh),
        .srcSigned1(mulSigned1),
        .srcSigned2(mulSigned2),
        .src1(src1),
        .src2(src2),
        .done(mulDone),
        .result(mulResult)
    );

    divUnit div (
        .clk(clk),
        .arstN(arstN),
        .enable(enable && !isMul),
        .stall(stall),
        .flush(flush),
        .isSigned(divSigned),
        .dividend(src1),
        .divisor(src2),
        .done(divDone),
        .quotient(quotient),
        .remainder(remainder)
    );

    always_comb begin
        if (isMul) begin
            done = mulDone;
            result = mulResult;
        end else begin
            done = divDone;
            // rem and remu take the remainder
            result = (kind inside {rvPkg::mulDivRem, rvPkg::mulDivRemu}) ? remainder : quotient;
        end
    end

    // a finished unit is only seen while its op is still presented
    doneNeedsEnable: assert property (
        @(posedge clk) disable iff (!arstN || flush) done |-> enable
    );

endmodule

`default_nettype wire

// File: source/mulUnit.sv
// Two-cycle 32x32 multiplier
// operands extended to 33 bits by their sign controls, returns low or high half
`timescale 1ns/1ps
`default_nettype none

module mulUnit (
    input logic clk,
    input logic arstN,
    input logic enable,
    input logic stall,
    input logic flush,
    input logic high,
    input logic srcSigned1,
    input logic srcSigned2,
    input rvPkg::word src1,
    input rvPkg::word src2,
    output logic done,
    output rvPkg::word result
);
    logic busy;
    logic signed [32:0] opA;
    logic signed [32:0] opB;
    logic signed [65:0] product;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (flush || !enable) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (!stall) begin
            if (done) begin
                done <= 1'b0;
            end else if (busy) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                busy <= 1'b1;
            end
        end
    end

    // first cycle captures operands, second the product
    always_ff @(posedge clk) begin
        if (!stall && !done) begin
            if (!busy) begin
                opA <= {srcSigned1 & src1[31], src1};
                opB <= {srcSigned2 & src2[31], src2};
            end else begin
                product <= opA * opB;
            end
        end
    end

    assign result = high ? product[63:32] : product[31:0];

endmodule

`default_nettype wire

// File: source/rvPkg.sv
// RV32IM ISA-level definitions
// data word, ALU commands, branch kinds, multiply/divide kinds and trap causes
`default_nettype none

package rvPkg;

    localparam int xLen = 32;
    // shift amount width
    localparam int xLenLog2 = 5;
    // byte step to the sequential pc
    localparam int insnSize = 4;

    typedef logic [xLen-1:0] word;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluCommand;

    typedef enum logic [2:0] {
        branchEqual,
        branchNotEqual,
        branchLessThan,
        branchGreaterEqual,
        branchUnsignedLessThan,
        branchUnsignedGreaterEqual,
        branchAlways
    } branchType;

    typedef enum logic [2:0] {
        mulDivMul,
        mulDivMulh,
        mulDivMulhsu,
        mulDivMulhu,
        mulDivDiv,
        mulDivDivu,
        mulDivRem,
        mulDivRemu
    } mulDivType;

    // mcause values, machine mode only
    typedef enum logic [3:0] {
        excBreakpoint = 4'd3,
        excEcallFromMachine = 4'd11
    } exceptionCode;

endpackage

`default_nettype wire

// File: src.f
source/rvPkg.sv
source/execPkg.sv
source/mulUnit.sv
source/divUnit.sv
source/mulDivUnit.sv
source/executeStage.sv
verification/executeStageTb.sv

// File: verification/executeStageTb.sv
// Execute stage testbench
// table of ALU, branch, jump, trap and multiply/divide cases, then random
// multiply/divide operands checked against a reference model of the M rules
`timescale 1ns/1ps
`default_nettype none

module executeStageTb;

    localparam int resetCycles = 10;
    localparam int numRandom = 24;
    // stall and flush sequences, counted as table entries for the run limit
    localparam int numSpecial = 4;
    localparam int cyclesPerEntry = 40;

    typedef enum logic [2:0] {
        kindAluReg,
        kindAluImm,
        kindBranch,
        kindJump,
        kindEcall,
        kindEbreak,
        kindMulDiv
    } opClass;

    typedef struct packed {
        opClass cls;
        rvPkg::aluCommand aluCmd;
        rvPkg::branchType branchKind;
        rvPkg::mulDivType mulDivKind;
        rvPkg::word pc;
        rvPkg::word src1;
        rvPkg::word src2;
        rvPkg::word imm;
        rvPkg::word expValue;
        logic expTaken;
        rvPkg::word expTarget;
        // zero when no trap is expected
        logic [3:0] expCause;
    } testEntry;

    logic clk;
    logic arstN;
    logic stall;
    logic flush;
    logic stallReq;
    execPkg::regReadOut prevStage;
    execPkg::executeOut nextStage;

    testEntry testTable[$];
    rvPkg::word rngState;
    int errorCount = 0;
    int testCount = 0;
    int cycleCount = 0;
    int timeoutLimit = 0;

    executeStage dut (
        .clk(clk),
        .arstN(arstN),
        .prevStage(prevStage),
        .stall(stall),
        .flush(flush),
        .stallReq(stallReq),
        .nextStage(nextStage)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            $display("timeout, the DUT gave no result within %0d cycles", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    task automatic compareValue(string signalName, rvPkg::word expected, rvPkg::word actual);
        if (expected !== actual) begin
            $display("Fail %0t %s expected %h actual %h", $time, signalName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTest(string testName, int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("%s: ok", testName);
        end else begin
            $display("%s: %0d mismatches", testName, errorCount - startErrors);
        end
    endtask

    // two LCG steps, upper halves only
    function automatic rvPkg::word randomWord();
        rvPkg::word hi;
        rvPkg::word lo;
        rngState = rngState * 32'd1103515245 + 32'd12345;
        hi = rngState;
        rngState = rngState * 32'd1103515245 + 32'd12345;
        lo = rngState;
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic rvPkg::word refMulDiv(rvPkg::mulDivType kind, rvPkg::word a,
                                             rvPkg::word b);
        longint sa;
        longint sb;
        longint ub;
        logic [63:0] product;
        logic overflow;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ub = longint'({32'd0, b});
        overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        case (kind)
            rvPkg::mulDivMul: product = sa * sb;
            rvPkg::mulDivMulh: product = sa * sb;
            rvPkg::mulDivMulhsu: product = sa * ub;
            rvPkg::mulDivMulhu: product = {32'd0, a} * {32'd0, b};
            default: product = '0;
        endcase
        case (kind)
            rvPkg::mulDivMul: return product[31:0];
            rvPkg::mulDivMulh: return product[63:32];
            rvPkg::mulDivMulhsu: return product[63:32];
            rvPkg::mulDivMulhu: return product[63:32];
            rvPkg::mulDivDiv: begin
                if (b == 32'd0) begin
                    return '1;
                end else if (overflow) begin
                    return a;
                end
                return rvPkg::word'(sa / sb);
            end
            rvPkg::mulDivRem: begin
                if (b == 32'd0) begin
                    return a;
                end else if (overflow) begin
                    return '0;
                end
                return rvPkg::word'(sa % sb);
            end
            rvPkg::mulDivDivu: return (b == 32'd0) ? '1 : a / b;
            rvPkg::mulDivRemu: return (b == 32'd0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    function automatic execPkg::decodedOp buildOp(testEntry e);
        execPkg::decodedOp op;
        op = '0;
        op.aluCmd = e.aluCmd;
        op.branchKind = e.branchKind;
        op.mulDivKind = e.mulDivKind;
        op.imm = e.imm;
        op.regWriteEnable = 1'b1;
        op.srcType1 = execPkg::src1Reg;
        op.srcType2 = execPkg::src2Reg;
        case (e.cls)
            kindAluImm: op.srcType2 = execPkg::src2Imm;
            kindBranch, kindJump: begin
                op.srcType1 = execPkg::src1Pc;
                op.srcType2 = execPkg::src2Imm;
                op.aluCmd = rvPkg::aluAdd;
                op.isBranch = 1'b1;
                op.regWriteEnable = (e.cls == kindJump);
                if (e.cls == kindJump) begin
                    op.branchKind = rvPkg::branchAlways;
                    op.writeSrc = execPkg::writeSrcNextPc;
                end
            end
            kindEcall: begin
                op.trapOp = execPkg::trapOpEcall;
                op.regWriteEnable = 1'b0;
            end
            kindEbreak: begin
                op.trapOp = execPkg::trapOpEbreak;
                op.regWriteEnable = 1'b0;
            end
            kindMulDiv: op.resultType = execPkg::intResultMulDiv;
            default: op.regWriteEnable = 1'b1;
        endcase
        return op;
    endfunction

    task automatic addAlu(rvPkg::aluCommand cmd, logic useImm, rvPkg::word a, rvPkg::word b,
                          rvPkg::word expected);
        testEntry e;
        e = '0;
        e.aluCmd = cmd;
        e.src1 = a;
        e.expValue = expected;
        // the unused operand slot gets the inverse, so a wrong select shows up
        if (useImm) begin
            e.cls = kindAluImm;
            e.imm = b;
            e.src2 = ~b;
        end else begin
            e.cls = kindAluReg;
            e.src2 = b;
            e.imm = ~b;
        end
        testTable.push_back(e);
    endtask

    task automatic addBranch(rvPkg::branchType kind, rvPkg::word pc, rvPkg::word a,
                             rvPkg::word b, rvPkg::word imm, logic taken);
        testEntry e;
        e = '0;
        e.cls = kindBranch;
        e.branchKind = kind;
        e.pc = pc;
        e.src1 = a;
        e.src2 = b;
        e.imm = imm;
        e.expTaken = taken;
        e.expTarget = pc + imm;
        testTable.push_back(e);
    endtask

    task automatic addJump(rvPkg::word pc, rvPkg::word imm);
        testEntry e;
        e = '0;
        e.cls = kindJump;
        e.pc = pc;
        e.imm = imm;
        e.expValue = pc + 32'd4;
        e.expTaken = 1'b1;
        e.expTarget = pc + imm;
        testTable.push_back(e);
    endtask

    task automatic addTrap(logic isEcall);
        testEntry e;
        e = '0;
        e.pc = 32'h0000_0500;
        if (isEcall) begin
            e.cls = kindEcall;
            e.expCause = 4'd11;
        end else begin
            e.cls = kindEbreak;
            e.expCause = 4'd3;
        end
        testTable.push_back(e);
    endtask

    task automatic addMulDiv(rvPkg::mulDivType kind, rvPkg::word a, rvPkg::word b,
                             rvPkg::word expected);
        testEntry e;
        e = '0;
        e.cls = kindMulDiv;
        e.mulDivKind = kind;
        e.src1 = a;
        e.src2 = b;
        e.expValue = expected;
        testTable.push_back(e);
    endtask

    task automatic fillTable();
        addAlu(rvPkg::aluAdd, 1'b0, 32'h0000_1234, 32'h0000_4321, 32'h0000_5555);
        addAlu(rvPkg::aluSub, 1'b0, 32'd5, 32'd7, 32'hFFFF_FFFE);
        // shift amounts above 31 keep only the low 5 bits
        addAlu(rvPkg::aluSll, 1'b0, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010);
        addAlu(rvPkg::aluSlt, 1'b0, 32'hFFFF_FFFF, 32'd1, 32'd1);
        addAlu(rvPkg::aluSltu, 1'b0, 32'hFFFF_FFFF, 32'd1, 32'd0);
        addAlu(rvPkg::aluXor, 1'b0, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'hFF00_FF00);
        addAlu(rvPkg::aluSrl, 1'b0, 32'h8000_0000, 32'h0000_003F, 32'h0000_0001);
        addAlu(rvPkg::aluSra, 1'b0, 32'h8000_0000, 32'd4, 32'hF800_0000);
        addAlu(rvPkg::aluOr, 1'b0, 32'h00FF_0000, 32'h0000_00FF, 32'h00FF_00FF);
        addAlu(rvPkg::aluAnd, 1'b0, 32'h1234_5678, 32'h0000_FFFF, 32'h0000_5678);
        addAlu(rvPkg::aluAdd, 1'b1, 32'h7FFF_FFFF, 32'd1, 32'h8000_0000);
        addAlu(rvPkg::aluSlt, 1'b1, 32'd5, 32'hFFFF_FFF0, 32'd0);
        addAlu(rvPkg::aluSltu, 1'b1, 32'd5, 32'hFFFF_FFF0, 32'd1);
        addAlu(rvPkg::aluXor, 1'b1, 32'h1234_5678, 32'hFFFF_FFFF, 32'hEDCB_A987);
        addAlu(rvPkg::aluOr, 1'b1, 32'h0000_0010, 32'h0000_0001, 32'h0000_0011);
        addAlu(rvPkg::aluAnd, 1'b1, 32'hFFFF_FFFF, 32'h0000_00F0, 32'h0000_00F0);
        addAlu(rvPkg::aluSll, 1'b1, 32'h0000_000F, 32'h0000_0420, 32'h0000_000F);
        addAlu(rvPkg::aluSrl, 1'b1, 32'hF000_0000, 32'h0000_001C, 32'h0000_000F);
        addAlu(rvPkg::aluSra, 1'b1, 32'h7F00_0000, 32'h0000_0038, 32'h0000_007F);
        addBranch(rvPkg::branchEqual, 32'h1000, 32'd5, 32'd5, 32'h40, 1'b1);
        addBranch(rvPkg::branchEqual, 32'h1004, 32'd5, 32'd6, 32'h40, 1'b0);
        addBranch(rvPkg::branchNotEqual, 32'h1008, 32'd5, 32'd6, 32'hFFFF_FFF0, 1'b1);
        addBranch(rvPkg::branchNotEqual, 32'h100C, 32'd7, 32'd7, 32'h80, 1'b0);
        addBranch(rvPkg::branchLessThan, 32'h1010, 32'hFFFF_FFFF, 32'd1, 32'h20, 1'b1);
        addBranch(rvPkg::branchLessThan, 32'h1014, 32'd1, 32'hFFFF_FFFF, 32'h20, 1'b0);
        addBranch(rvPkg::branchGreaterEqual, 32'h1018, 32'd1, 32'hFFFF_FFFF, 32'h8, 1'b1);
        addBranch(rvPkg::branchGreaterEqual, 32'h101C, 32'd3, 32'd3, 32'h8, 1'b1);
        addBranch(rvPkg::branchGreaterEqual, 32'h1020, 32'h8000_0000, 32'd0, 32'h8, 1'b0);
        addBranch(rvPkg::branchUnsignedLessThan, 32'h1024, 32'd1, 32'hFFFF_FFFF, 32'h10, 1'b1);
        addBranch(rvPkg::branchUnsignedLessThan, 32'h1028, 32'hFFFF_FFFF, 32'd1, 32'h10, 1'b0);
        addBranch(rvPkg::branchUnsignedGreaterEqual, 32'h102C, 32'hFFFF_FFFF, 32'd1,
                  32'hFFFF_FF00, 1'b1);
        addBranch(rvPkg::branchUnsignedGreaterEqual, 32'h1030, 32'd0, 32'd1, 32'h10, 1'b0);
        addJump(32'h0000_2000, 32'h0000_0100);
        addJump(32'h0000_3000, 32'hFFFF_F000);
        addTrap(1'b1);
        addTrap(1'b0);
        addMulDiv(rvPkg::mulDivMul, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
        addMulDiv(rvPkg::mulDivMulh, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        addMulDiv(rvPkg::mulDivMulh, 32'h8000_0000, 32'h7FFF_FFFF, 32'hC000_0000);
        addMulDiv(rvPkg::mulDivMulhsu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        addMulDiv(rvPkg::mulDivMulhu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
        addMulDiv(rvPkg::mulDivDiv, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
        addMulDiv(rvPkg::mulDivRem, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
        addMulDiv(rvPkg::mulDivDiv, 32'hFFFF_FFF9, 32'd0, 32'hFFFF_FFFF);
        addMulDiv(rvPkg::mulDivRem, 32'hFFFF_FFF9, 32'd0, 32'hFFFF_FFF9);
        addMulDiv(rvPkg::mulDivDivu, 32'h1234_5678, 32'd0, 32'hFFFF_FFFF);
        addMulDiv(rvPkg::mulDivRemu, 32'h1234_5678, 32'd0, 32'h1234_5678);
        addMulDiv(rvPkg::mulDivDiv, 32'hFFFF_FFF9, 32'd2, 32'hFFFF_FFFD);
        addMulDiv(rvPkg::mulDivRem, 32'hFFFF_FFF9, 32'd2, 32'hFFFF_FFFF);
        addMulDiv(rvPkg::mulDivDivu, 32'd100, 32'd7, 32'd14);
        addMulDiv(rvPkg::mulDivRemu, 32'd100, 32'd7, 32'd2);
    endtask

    task automatic driveEntry(testEntry e);
        prevStage.valid = 1'b1;
        prevStage.op = buildOp(e);
        prevStage.pc = e.pc;
        prevStage.srcValue1 = e.src1;
        prevStage.srcValue2 = e.src2;
        prevStage.dstRegAddr = 5'd1;
    endtask

    // input stays put while stallReq is high, so just watch for valid
    task automatic waitForResult();
        do begin
            @(negedge clk);
        end while (!nextStage.valid);
    endtask

    // stallReq drops once the unit has its result ready
    task automatic waitForMulDivDone();
        do begin
            @(negedge clk);
        end while (stallReq);
    endtask

    task automatic applyEntry(testEntry e, string testName);
        int startErrors;
        startErrors = errorCount;
        driveEntry(e);
        waitForResult();
        prevStage.valid = 1'b0;
        compareValue("nextStage.pc", e.pc, nextStage.pc);
        compareValue("nextStage.dstRegAddr", 32'd1, 32'(nextStage.dstRegAddr));
        compareValue("nextStage.storeValue", e.src2, nextStage.storeValue);
        compareValue("nextStage.op unchanged", 32'd1, 32'(nextStage.op == buildOp(e)));
        compareValue("nextStage.branchTaken", 32'(e.expTaken), 32'(nextStage.branchTaken));
        if (e.cls == kindBranch || e.cls == kindJump) begin
            compareValue("nextStage.branchTarget", e.expTarget, nextStage.branchTarget);
            compareValue("nextStage.memAddr", e.expTarget, nextStage.memAddr);
        end
        if (e.cls == kindAluReg || e.cls == kindAluImm) begin
            compareValue("nextStage.memAddr", e.expValue, nextStage.memAddr);
        end
        if (e.cls != kindBranch && e.cls != kindEcall && e.cls != kindEbreak) begin
            compareValue("nextStage.dstValue", e.expValue, nextStage.dstValue);
        end
        compareValue("nextStage.trap.valid", 32'(e.expCause != 4'd0),
                     32'(nextStage.trap.valid));
        if (e.expCause != 4'd0) begin
            compareValue("nextStage.trap.cause", 32'(e.expCause), 32'(nextStage.trap.cause));
        end
        reportTest(testName, startErrors);
    endtask

    task automatic holdStall(int cycles);
        execPkg::executeOut held;
        held = nextStage;
        stall = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            compareValue("stalled nextStage.valid", 32'(held.valid), 32'(nextStage.valid));
            compareValue("stalled nextStage.dstValue", held.dstValue, nextStage.dstValue);
            compareValue("stalled nextStage unchanged", 32'd1, 32'(held == nextStage));
        end
        stall = 1'b0;
    endtask

    task automatic stallTest();
        int startErrors;
        testEntry e;
        startErrors = errorCount;
        e = '0;
        e.cls = kindMulDiv;
        e.mulDivKind = rvPkg::mulDivDivu;
        e.pc = 32'h0000_0300;
        e.src1 = 32'd1000;
        e.src2 = 32'd7;
        e.expValue = 32'd142;
        driveEntry(e);
        // frozen before the divide starts, then again with the quotient ready
        holdStall(5);
        waitForMulDivDone();
        holdStall(5);
        waitForResult();
        prevStage.valid = 1'b0;
        compareValue("nextStage.pc", e.pc, nextStage.pc);
        compareValue("nextStage.dstValue", e.expValue, nextStage.dstValue);
        reportTest("stall during divide", startErrors);
    endtask

    task automatic flushTest();
        int startErrors;
        testEntry first;
        testEntry second;
        startErrors = errorCount;
        first = '0;
        first.cls = kindMulDiv;
        first.mulDivKind = rvPkg::mulDivRem;
        first.pc = 32'h0000_0100;
        first.src1 = 32'd12345;
        first.src2 = 32'd100;
        second = first;
        second.mulDivKind = rvPkg::mulDivDiv;
        second.pc = 32'h0000_0200;
        second.src1 = 32'hFFFF_0000;
        second.src2 = 32'h0000_0100;
        second.expValue = 32'hFFFF_FF00;
        driveEntry(first);
        // flush in the cycle the remainder would register
        waitForMulDivDone();
        flush = 1'b1;
        @(negedge clk);
        compareValue("flushed nextStage.valid", 32'd0, 32'(nextStage.valid));
        compareValue("flushed nextStage any bit", 32'd0, 32'(|nextStage));
        flush = 1'b0;
        driveEntry(second);
        waitForResult();
        prevStage.valid = 1'b0;
        compareValue("nextStage.pc", second.pc, nextStage.pc);
        compareValue("nextStage.dstValue", second.expValue, nextStage.dstValue);
        reportTest("flush during divide", startErrors);
    endtask

    initial begin
        int startErrors;
        testEntry e;
        rvPkg::mulDivType kind;
        clk = 1'b0;
        arstN = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        prevStage = '0;
        rngState = 32'h5d55;
        fillTable();
        timeoutLimit = (testTable.size() + numRandom + numSpecial) * cyclesPerEntry
                       + resetCycles;

        repeat (resetCycles) @(negedge clk);
        startErrors = errorCount;
        compareValue("nextStage.valid", 32'd0, 32'(nextStage.valid));
        compareValue("nextStage any bit", 32'd0, 32'(|nextStage));
        compareValue("stallReq", 32'd0, 32'(stallReq));
        arstN = 1'b1;
        reportTest("reset state", startErrors);

        foreach (testTable[i]) begin
            applyEntry(testTable[i], $sformatf("entry %0d %s", i, testTable[i].cls.name()));
        end

        for (int i = 0; i < numRandom; i++) begin
            kind = rvPkg::mulDivType'(3'(i));
            e = '0;
            e.cls = kindMulDiv;
            e.mulDivKind = kind;
            e.pc = 32'h0000_4000 + 32'(i * 4);
            e.src1 = randomWord();
            e.src2 = randomWord();
            e.expValue = refMulDiv(kind, e.src1, e.src2);
            applyEntry(e, $sformatf("random %0d %s", i, kind.name()));
        end

        stallTest();
        flushTest();

        $display("%0d tests run, %0d mismatches", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
